// ==== hdl/arb_pri_rr.sv ====
// Round-robin arbiter with a one-bit priority per requester, used as the core of the WRR arbiter
`timescale 1ns/100ps

module arb_pri_rr #(
  parameter int NumRequesters = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     enable_priority_update,
  input  logic [NumRequesters-1:0] request,
  input  logic [NumRequesters-1:0] request_priority,
  output logic [NumRequesters-1:0] grant
);

  // Index width of the round-robin pointer
  localparam int PtrWidth = $clog2(NumRequesters);

  // Pointer to the requester that is checked first
  logic [PtrWidth-1:0] rr_ptr;
  logic [PtrWidth-1:0] grant_idx;
  logic                grant_found;
  logic [NumRequesters-1:0] high_request;
  logic [NumRequesters-1:0] eligible;

  // ------------------------------------------------------------
  // Eligibility
  // ------------------------------------------------------------

  // High-priority requests shadow the rest whenever any of them is present
  assign high_request = request & request_priority;
  assign eligible = (|high_request) ? high_request : request;

  // ------------------------------------------------------------
  // Grant search
  // ------------------------------------------------------------

  // Walk the requesters starting at the pointer and wrap around once
  always_comb begin
    int idx;
    grant = '0;
    grant_idx = '0;
    grant_found = 1'b0;
    for (int k = 0; k < NumRequesters; k++) begin
      idx = int'(rr_ptr) + k;
      if (idx >= NumRequesters) begin
        idx = idx - NumRequesters;
      end
      // Only the first eligible requester on the walk is taken
      if (!grant_found && eligible[idx]) begin
        grant_found = 1'b1;
        grant[idx] = 1'b1;
        grant_idx = PtrWidth'(idx);
      end
    end
  end

  // ------------------------------------------------------------
  // Pointer update
  // ------------------------------------------------------------

  // The pointer moves to just past the grantee, so that requester goes last next round
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (enable_priority_update && grant_found) begin
      if (grant_idx == PtrWidth'(NumRequesters - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_idx + PtrWidth'(1);
      end
    end
  end

endmodule

// ==== hdl/arb_weighted_rr.sv ====
// Weighted round-robin arbiter that shares grants in proportion to per-port weights
`timescale 1ns/100ps
`include "wrr_settings.svh"

module arb_weighted_rr (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enable_priority_update,
  input  wrr_pkg::port_mask_t  request,
  input  wrr_pkg::weight_vec_t request_weight,
  output wrr_pkg::port_mask_t  grant
);

  import wrr_pkg::*;

  // A port with credit left in its accumulator is high priority
  port_mask_t request_priority;
  accum_t     accum [`WRR_NUM_PORTS];

  // Refill strobe shared by all accumulators
  logic       any_high_request;
  logic       refill;
  // Per-port decrement, only the grantee of an accepted transfer
  port_mask_t spend;

  // ------------------------------------------------------------
  // Arbitration core
  // ------------------------------------------------------------

  // Two priority levels: ports with credit first, round robin inside each level
  arb_pri_rr #(
    .NumRequesters(`WRR_NUM_PORTS)
  ) arb_pri_rr_i (
    .clk                    (clk),
    .rst                    (rst),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .request_priority       (request_priority),
    .grant                  (grant)
  );

  // ------------------------------------------------------------
  // Credit accounting
  // ------------------------------------------------------------

  // All requesters are out of credit, so every port is topped up by its weight
  assign any_high_request = |(request & request_priority);
  assign refill = enable_priority_update && (|request) && !any_high_request;
  assign spend = enable_priority_update ? grant : '0;

  // The grantee adds before it spends, so a refill grant never underflows
  for (genvar i = 0; i < `WRR_NUM_PORTS; i++) begin : gen_accum
    sat_counter #(
      .MaxValue  (`WRR_MAX_ACCUM_WEIGHT),
      .MaxChange (`WRR_MAX_WEIGHT)
    ) sat_counter_i (
      .clk        (clk),
      .rst        (rst),
      .incr_valid (refill),
      .incr       (request_weight[i]),
      .decr_valid (spend[i]),
      .value      (accum[i])
    );

    // Non-zero credit raises the port to the high level
    assign request_priority[i] = |accum[i];
  end

endmodule

// ==== hdl/sat_counter.sv ====
// Saturating up/down accumulator, one per port inside the WRR arbiter
`timescale 1ns/100ps

module sat_counter #(
  parameter int MaxValue = 1,
  parameter int MaxChange = 1,
  localparam int ValueWidth = $clog2(MaxValue + 1),
  localparam int ChangeWidth = $clog2(MaxChange + 1)
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   incr_valid,
  input  logic [ChangeWidth-1:0] incr,
  input  logic                   decr_valid,
  output logic [ValueWidth-1:0]  value
);

  // Wide enough that the add can never wrap before the clamp
  localparam int SumWidth = $clog2(MaxValue + MaxChange + 1);

  logic [SumWidth-1:0]   sum_after_add;
  logic [SumWidth-1:0]   sum_after_sub;
  logic [ValueWidth-1:0] value_next;

  // Add first, then take one away, then clamp to the upper limit
  always_comb begin
    sum_after_add = SumWidth'(value);
    if (incr_valid) begin
      sum_after_add = sum_after_add + SumWidth'(incr);
    end
    // The subtract stops at zero instead of wrapping
    sum_after_sub = sum_after_add;
    if (decr_valid && (sum_after_add != '0)) begin
      sum_after_sub = sum_after_add - SumWidth'(1);
    end
    if (sum_after_sub > SumWidth'(MaxValue)) begin
      value_next = ValueWidth'(MaxValue);
    end else begin
      value_next = ValueWidth'(sum_after_sub);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      value <= '0;
    end else begin
      value <= value_next;
    end
  end

endmodule

// ==== hdl/weight_regs.sv ====
// Per-port weight registers of the WRR merger, written by software through a strobe
`timescale 1ns/100ps
`include "wrr_settings.svh"

module weight_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cfg_write,
  input  wrr_pkg::port_idx_t   cfg_port,
  input  wrr_pkg::weight_t     cfg_weight,
  output wrr_pkg::weight_vec_t weight
);

  import wrr_pkg::*;

  // A zero weight would starve its port, so such writes are dropped
  logic write_ok;

  assign write_ok = cfg_write && (cfg_weight != weight_t'(0));

  // Every port starts with weight one, which gives plain round robin
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `WRR_NUM_PORTS; i++) begin
        weight[i] <= weight_t'(1);
      end
    end else if (write_ok) begin
      // The arbiter sees the new value from the next cycle on
      weight[cfg_port] <= cfg_weight;
    end
  end

endmodule

// ==== hdl/wrr_pkg.sv ====
// Shared vector types of the weighted round-robin merger, imported by every RTL block
`include "wrr_settings.svh"

package wrr_pkg;

  // ------------------------------------------------------------
  // Field widths derived from the settings
  // ------------------------------------------------------------

  // Each width is the smallest one that holds its largest value
  localparam int WeightWidth = $clog2(`WRR_MAX_WEIGHT + 1);
  localparam int AccumWidth = $clog2(`WRR_MAX_ACCUM_WEIGHT + 1);
  localparam int PortIdxWidth = $clog2(`WRR_NUM_PORTS);

  // One bit per port, shared by requests, grants and readies
  typedef logic [`WRR_NUM_PORTS-1:0] port_mask_t;

  typedef logic [WeightWidth-1:0] weight_t;
  typedef weight_t [`WRR_NUM_PORTS-1:0] weight_vec_t;
  typedef logic [AccumWidth-1:0] accum_t;
  typedef logic [`WRR_DATA_WIDTH-1:0] data_t;
  typedef data_t [`WRR_NUM_PORTS-1:0] data_vec_t;
  typedef logic [PortIdxWidth-1:0] port_idx_t;

endpackage

// ==== hdl/wrr_port_mux.sv ====
// Top level of the WRR packet merger joining weights, arbiter and output data multiplexer
`timescale 1ns/100ps
`include "wrr_settings.svh"

module wrr_port_mux (
  input  logic                clk,
  input  logic                rst,
  input  wrr_pkg::port_mask_t in_valid,
  input  wrr_pkg::data_vec_t  in_data,
  output wrr_pkg::port_mask_t in_ready,
  output logic                out_valid,
  output wrr_pkg::data_t      out_data,
  input  logic                out_ready,
  input  logic                cfg_write,
  input  wrr_pkg::port_idx_t  cfg_port,
  input  wrr_pkg::weight_t    cfg_weight
);

  import wrr_pkg::*;

  weight_vec_t weight;
  // One-hot grant, or zero when no port is valid
  port_mask_t  grant;
  logic        xfer_accept;

  // ------------------------------------------------------------
  // Configuration and arbitration
  // ------------------------------------------------------------

  weight_regs weight_regs_i (
    .clk        (clk),
    .rst        (rst),
    .cfg_write  (cfg_write),
    .cfg_port   (cfg_port),
    .cfg_weight (cfg_weight),
    .weight     (weight)
  );

  // Arbiter state moves only when the output handshake completes
  arb_weighted_rr arb_weighted_rr_i (
    .clk                    (clk),
    .rst                    (rst),
    .enable_priority_update (xfer_accept),
    .request                (in_valid),
    .request_weight         (weight),
    .grant                  (grant)
  );

  // ------------------------------------------------------------
  // Handshake and data path
  // ------------------------------------------------------------

  assign out_valid = |grant;
  assign xfer_accept = out_valid && out_ready;
  // Only the grantee sees ready, and only when the sink takes the word
  assign in_ready = grant & {`WRR_NUM_PORTS{out_ready}};

  // AND-OR multiplexer, valid because the grant is one-hot
  always_comb begin
    out_data = '0;
    for (int i = 0; i < `WRR_NUM_PORTS; i++) begin
      if (grant[i]) begin
        out_data = out_data | in_data[i];
      end
    end
  end

endmodule

// ==== hdl/wrr_settings.svh ====
// Build-time sizing of the weighted round-robin merger, included by the package and the RTL
`ifndef WRR_SETTINGS_SVH
`define WRR_SETTINGS_SVH

// ------------------------------------------------------------
// Port and data sizing
// ------------------------------------------------------------

// Number of input ports feeding the merger
`define WRR_NUM_PORTS 4

// Width of one data word on every input and on the output
`define WRR_DATA_WIDTH 16

// ------------------------------------------------------------
// Weight limits
// ------------------------------------------------------------

// Largest weight software may program for one port
`define WRR_MAX_WEIGHT 7

// Saturation limit of each accumulator, at least the largest weight
`define WRR_MAX_ACCUM_WEIGHT 14

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds the WRR merger testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f \
  --top-module wrr_port_mux_tb -o wrr_sim

# An assertion that fires stops the simulation with a failing status.
./obj_dir/wrr_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without a reported failure"
exit 0

// ==== sources.f ====
+incdir+hdl
hdl/wrr_pkg.sv
hdl/arb_pri_rr.sv
hdl/sat_counter.sv
hdl/arb_weighted_rr.sv
hdl/weight_regs.sv
hdl/wrr_port_mux.sv
verification/wrr_assertions.sv
verification/wrr_checker.sv
verification/wrr_port_mux_tb.sv

// ==== verification/wrr_assertions.sv ====
// Concurrent handshake and grant assertions, attached to wrr_port_mux through bind
`timescale 1ns/100ps

module wrr_assertions (
  input logic                clk,
  input logic                rst,
  input wrr_pkg::port_mask_t in_valid,
  input wrr_pkg::port_mask_t in_ready,
  input logic                out_valid,
  input logic                out_ready,
  input wrr_pkg::port_mask_t grant
);

  // ------------------------------------------------------------
  // Grant shape and output valid
  // ------------------------------------------------------------

  // The data multiplexer is an AND-OR tree and needs at most one grant
  grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant has more than one bit set");

  // The output can only be valid when some port offers a word
  valid_has_source: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (in_valid != '0))
    else $error("out_valid is high while no input port is valid");

  // ------------------------------------------------------------
  // Back-pressure
  // ------------------------------------------------------------

  // No input may see ready while the sink refuses the word
  no_ready_when_stalled: assert property (@(posedge clk) disable iff (rst)
    !out_ready |-> (in_ready == '0))
    else $error("in_ready is high while out_ready is low");

  // A stalled sink freezes the arbiter, so unchanged requests keep their grant
  grant_holds_when_stalled: assert property (@(posedge clk) disable iff (rst)
    !out_ready |=> (!$stable(in_valid) || $stable(grant)))
    else $error("grant changed under back-pressure with unchanged requests");

endmodule

// ==== verification/wrr_checker.sv ====
// Reference model of the WRR arbitration that checks every accepted output transfer
`timescale 1ns/100ps
`include "wrr_settings.svh"

module wrr_checker (
  input logic                 clk,
  input logic                 rst,
  input wrr_pkg::port_mask_t  in_valid,
  input wrr_pkg::data_vec_t   in_data,
  input wrr_pkg::port_mask_t  in_ready,
  input logic                 out_valid,
  input wrr_pkg::data_t       out_data,
  input logic                 out_ready,
  input logic                 cfg_write,
  input wrr_pkg::port_idx_t   cfg_port,
  input wrr_pkg::weight_t     cfg_weight
);

  import wrr_pkg::*;

  localparam int NumPorts = `WRR_NUM_PORTS;

  // Model state: pointer, credits and weights as the arbitration rules define them
  int    model_ptr;
  int    model_accum [NumPorts];
  int    model_weight [NumPorts];
  int    grant_count [NumPorts];
  string test_name = "idle";
  int    row_errors = 0;
  int    pass_tests = 0;
  int    fail_tests = 0;

  // ------------------------------------------------------------
  // Model of the arbitration rules
  // ------------------------------------------------------------

  // Ports with credit go first, then the first eligible port at or after the pointer
  function automatic int next_grant();
    logic [NumPorts-1:0] high;
    logic [NumPorts-1:0] eligible;
    int idx;
    for (int i = 0; i < NumPorts; i++) begin
      high[i] = in_valid[i] && (model_accum[i] != 0);
    end
    eligible = (high != '0) ? high : in_valid;
    for (int k = 0; k < NumPorts; k++) begin
      idx = (model_ptr + k) % NumPorts;
      if (eligible[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic note_error(input string text);
    $display("%s", text);
    row_errors++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    row_errors = 0;
    for (int i = 0; i < NumPorts; i++) begin
      grant_count[i] = 0;
    end
  endtask

  // Compares the grant counts of the finished test and prints its result line
  task automatic end_test(input int e0, input int e1, input int e2, input int e3);
    int expected [NumPorts];
    expected = '{e0, e1, e2, e3};
    for (int i = 0; i < NumPorts; i++) begin
      if (grant_count[i] != expected[i]) begin
        note_error($sformatf("FAIL %s: port %0d grants expected %0d actual %0d",
                             test_name, i, expected[i], grant_count[i]));
      end
    end
    if (row_errors == 0) begin
      $display("PASS %s: grants %0d %0d %0d %0d", test_name,
               grant_count[0], grant_count[1], grant_count[2], grant_count[3]);
      pass_tests++;
    end else begin
      $display("FAIL %s: %0d checks did not match", test_name, row_errors);
      fail_tests++;
    end
  endtask

  // ------------------------------------------------------------
  // Transfer monitor
  // ------------------------------------------------------------

  always @(posedge clk) begin
    int   exp_port;
    logic any_high;
    if (rst) begin
      // Reset mirrors the DUT: pointer at port 0, no credit, unit weights
      model_ptr = 0;
      for (int i = 0; i < NumPorts; i++) begin
        model_accum[i] = 0;
        model_weight[i] = 1;
      end
    end else begin
      if ((in_valid != '0) && !out_valid) begin
        note_error($sformatf("%s: out_valid stayed low although a port was valid", test_name));
      end
      if (out_valid && out_ready) begin
        exp_port = next_grant();
        if (exp_port < 0) begin
          note_error($sformatf("%s: a word was accepted while no port was valid", test_name));
        end else begin
          if (in_ready != (port_mask_t'(1) << exp_port)) begin
            note_error($sformatf("FAIL %s: in_ready expected %b actual %b", test_name,
                                 port_mask_t'(1) << exp_port, in_ready));
          end
          if (out_data != in_data[exp_port]) begin
            note_error($sformatf("FAIL %s: out_data expected %h actual %h", test_name,
                                 in_data[exp_port], out_data));
          end
          any_high = 1'b0;
          for (int i = 0; i < NumPorts; i++) begin
            any_high = any_high | (in_valid[i] && (model_accum[i] != 0));
          end
          // A refill tops up every port and clamps at the accumulator limit
          if (!any_high) begin
            for (int i = 0; i < NumPorts; i++) begin
              model_accum[i] = model_accum[i] + model_weight[i];
              if (model_accum[i] > `WRR_MAX_ACCUM_WEIGHT) begin
                model_accum[i] = `WRR_MAX_ACCUM_WEIGHT;
              end
            end
          end
          if (model_accum[exp_port] > 0) begin
            model_accum[exp_port] = model_accum[exp_port] - 1;
          end
          model_ptr = (exp_port + 1) % NumPorts;
          grant_count[exp_port]++;
        end
      end
      // Writes of zero are dropped, any other weight counts from the next cycle
      if (cfg_write && (cfg_weight != '0)) begin
        model_weight[cfg_port] = int'(cfg_weight);
      end
    end
  end

endmodule

// ==== verification/wrr_port_mux_tb.sv ====
// Testbench top of the WRR merger that runs the stimulus table and prints the verdict
`timescale 1ns/100ps
`include "wrr_settings.svh"

module wrr_port_mux_tb;

  import wrr_pkg::*;

  localparam int ClkPeriod = 8;
  localparam int NumRows = 6;
  localparam int ModeAlways = 0;
  localparam int ModeRandom = 1;
  localparam int ModeStall = 2;

  logic       clk;
  logic       rst;
  port_mask_t in_valid;
  data_vec_t  in_data;
  port_mask_t in_ready;
  logic       out_valid;
  data_t      out_data;
  logic       out_ready;
  logic       cfg_write;
  port_idx_t  cfg_port;
  weight_t    cfg_weight;

  // Stimulus table with one entry per test row
  string      row_name [NumRows];
  int         row_weight [NumRows][`WRR_NUM_PORTS];
  int         row_zero_port [NumRows];
  port_mask_t row_mask [NumRows];
  int         row_mode [NumRows];
  int         row_xfers [NumRows];
  int         row_retune_at [NumRows];
  int         row_expect [NumRows][`WRR_NUM_PORTS];
  logic       table_loaded;

  wrr_port_mux wrr_port_mux_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .cfg_write  (cfg_write),
    .cfg_port   (cfg_port),
    .cfg_weight (cfg_weight)
  );

  wrr_checker checker_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .cfg_write  (cfg_write),
    .cfg_port   (cfg_port),
    .cfg_weight (cfg_weight)
  );

  bind wrr_port_mux wrr_assertions wrr_assertions_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .grant     (grant)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------

  task automatic set_row(input int r, input string name, input int w0, input int w1,
                         input int w2, input int w3, input int zero_port,
                         input port_mask_t mask, input int mode, input int xfers,
                         input int retune_at, input int e0, input int e1, input int e2,
                         input int e3);
    row_name[r] = name;
    row_weight[r] = '{w0, w1, w2, w3};
    row_zero_port[r] = zero_port;
    row_mask[r] = mask;
    row_mode[r] = mode;
    row_xfers[r] = xfers;
    row_retune_at[r] = retune_at;
    row_expect[r] = '{e0, e1, e2, e3};
  endtask

  // Weights 1,2,3,4 give ten grants per refill, split exactly by weight
  // The config row refills 8 grants at weight 2 each, then 9 per refill once port 1 has 3
  task automatic load_table();
    set_row(0, "single_port", 1, 1, 1, 1, -1, 4'b0100, ModeAlways, 20, -1, 0, 0, 20, 0);
    set_row(1, "equal_weights", 1, 1, 1, 1, -1, 4'b1111, ModeAlways, 40, -1, 10, 10, 10, 10);
    set_row(2, "proportional", 1, 2, 3, 4, -1, 4'b1111, ModeAlways, 100, -1, 10, 20, 30, 40);
    set_row(3, "random_ready", 1, 2, 3, 4, -1, 4'b1111, ModeRandom, 100, -1, 10, 20, 30, 40);
    set_row(4, "stall_windows", 1, 2, 3, 4, -1, 4'b1111, ModeStall, 100, -1, 10, 20, 30, 40);
    set_row(5, "config_write", 2, 2, 2, 2, 1, 4'b1111, ModeAlways, 26, 8, 6, 8, 6, 6);
  endtask

  // ------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    in_valid <= '0;
    out_ready <= 1'b0;
    cfg_write <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic write_weight(input int port, input int weight);
    @(posedge clk);
    cfg_write <= 1'b1;
    cfg_port <= port_idx_t'(port);
    cfg_weight <= weight_t'(weight);
    @(posedge clk);
    cfg_write <= 1'b0;
  endtask

  function automatic logic ready_for(input int mode, input int cycle);
    if (mode == ModeRandom) begin
      return ($urandom % 10) < 7;
    end else if (mode == ModeStall) begin
      // Five stalled cycles out of every fifteen
      return ((cycle / 5) % 3) != 2;
    end
    return 1'b1;
  endfunction

  // Holds the request mask and counts accepted words until the row is complete
  task automatic run_row(input int r);
    int count;
    int cycle;
    logic retuned;
    count = 0;
    cycle = 0;
    retuned = 1'b0;
    @(posedge clk);
    in_valid <= row_mask[r];
    for (int i = 0; i < `WRR_NUM_PORTS; i++) begin
      in_data[i] <= data_t'($urandom);
    end
    while (count < row_xfers[r]) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        count++;
      end
      // An accepted word is replaced by a fresh one on its port
      for (int i = 0; i < `WRR_NUM_PORTS; i++) begin
        if (in_valid[i] && in_ready[i]) begin
          in_data[i] <= data_t'($urandom);
        end
      end
      cfg_write <= 1'b0;
      if (count == row_xfers[r]) begin
        // The sink stays ready for one idle cycle in which no word may appear
        in_valid <= '0;
        out_ready <= 1'b1;
      end else if (row_retune_at[r] >= 0 && count == row_retune_at[r] && !retuned) begin
        // Retune port 1 while the sink pauses, right at a refill boundary
        out_ready <= 1'b0;
        cfg_write <= 1'b1;
        cfg_port <= port_idx_t'(1);
        cfg_weight <= weight_t'(3);
        retuned = 1'b1;
      end else begin
        out_ready <= ready_for(row_mode[r], cycle);
      end
      cycle++;
    end
    @(posedge clk);
    out_ready <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // Watchdog and main sequence
  // ------------------------------------------------------------

  initial begin
    int total;
    total = 0;
    wait (table_loaded === 1'b1);
    for (int r = 0; r < NumRows; r++) begin
      total = total + row_xfers[r];
    end
    #(4 * total * ClkPeriod + 2000);
    $display("Timeout: the tests did not finish in time, the DUT stopped moving words");
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h8af851fb));
    clk = 1'b0;
    rst = 1'b1;
    in_valid = '0;
    in_data = '0;
    out_ready = 1'b0;
    cfg_write = 1'b0;
    cfg_port = '0;
    cfg_weight = '0;
    table_loaded = 1'b0;
    load_table();
    table_loaded = 1'b1;
    for (int r = 0; r < NumRows; r++) begin
      // Reset restores unit weights, so the row's weights go in afterwards
      apply_reset();
      for (int p = 0; p < `WRR_NUM_PORTS; p++) begin
        write_weight(p, row_weight[r][p]);
      end
      if (row_zero_port[r] >= 0) begin
        write_weight(row_zero_port[r], 0);
      end
      checker_i.start_test(row_name[r]);
      run_row(r);
      @(posedge clk);
      checker_i.end_test(row_expect[r][0], row_expect[r][1], row_expect[r][2],
                         row_expect[r][3]);
    end
    $display("Summary: %0d rows passed, %0d rows failed", checker_i.pass_tests,
             checker_i.fail_tests);
    if (checker_i.fail_tests == 0 && checker_i.pass_tests == NumRows) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
